// File: dbg_bp_match.sv
// Breakpoint compare, single-step and branch-break detection
`timescale 1ns/1ps
`default_nettype none

module dbg_bp_match #(
  parameter int XLEN = 32
) (
  input  logic                                instr_break_ena,
  input  logic                                branch_break_ena,
  input  logic [dbg_pkg::MAX_BREAKPOINTS-1:0] bp_enabled,
  input  dbg_pkg::bp_cc_e                     bp_cc [dbg_pkg::MAX_BREAKPOINTS],
  input  logic [XLEN-1:0]                     bp_data [dbg_pkg::MAX_BREAKPOINTS],
  input  logic [XLEN-1:0]                     if_pc,
  input  logic [dbg_pkg::ILEN-1:0]            if_instr,
  input  logic                                if_bubble,
  input  logic [dbg_pkg::ILEN-1:0]            mem_instr,
  input  logic                                mem_bubble,
  input  logic [dbg_pkg::EXC_SIZE-1:0]        mem_exception,
  input  logic [XLEN-1:0]                     mem_memadr,
  input  logic                                dmem_ack,
  input  logic                                bu_flush,
  input  logic                                st_flush,
  output logic                                bp_instr_hit,
  output logic                                bp_branch_hit,
  output logic [dbg_pkg::MAX_BREAKPOINTS-1:0] bp_hit
);
  import dbg_pkg::*;

  logic fetch_ok;
  logic mem_ok;
  logic mem_read;
  logic mem_write;

  // Single step, every real fetch
  assign bp_instr_hit  = instr_break_ena & ~if_bubble;
  assign bp_branch_hit = branch_break_ena & ~if_bubble & (if_instr[6:2] == OPC_BRANCH);

  // Fetch PC not being thrown away
  assign fetch_ok = ~bu_flush & ~st_flush;

  // Access that actually completes in MEM
  assign mem_ok    = ~|mem_exception & ~mem_bubble;
  assign mem_read  = mem_ok & (mem_instr[6:2] == OPC_LOAD);
  assign mem_write = mem_ok & (mem_instr[6:2] == OPC_STORE);

  // Unimplemented slots are never enabled
  always_comb begin
    for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
      bp_hit[n] = 1'b0;
      if (bp_enabled[n]) begin
        case (bp_cc[n])
          CC_FETCH:    bp_hit[n] = (if_pc == bp_data[n]) & fetch_ok;
          CC_LD_ADR:   bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & mem_read;
          CC_ST_ADR:   bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & mem_write;
          CC_LDST_ADR: bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack &
                                   (mem_read | mem_write);
          default:     bp_hit[n] = 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: dbg_pkg.sv
// Debug address split, register map enums, breakpoint compare codes and opcodes
`default_nettype none

package dbg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  // Host address is bank plus offset
  localparam int DBG_AW       = 16;
  localparam int DU_ADDR_SIZE = 12;
  localparam int BANK_W       = DBG_AW - DU_ADDR_SIZE;

  // Slots in the register map, not all implemented
  localparam int MAX_BREAKPOINTS = 8;

  // Pipeline side
  localparam int EXC_SIZE = 16;
  localparam int ILEN     = 32;

  //////////////////////////////////////////////////////////////////////
  // Register map

  // Upper address nibble
  typedef enum logic [BANK_W-1:0] {
    BANK_INTERNAL = 4'h0,
    BANK_GPRS     = 4'h1
  } dbg_bank_e;

  // Internal bank offsets
  typedef enum logic [DU_ADDR_SIZE-1:0] {
    REG_CTRL    = 12'h000,
    REG_HIT     = 12'h001,
    REG_IE      = 12'h002,
    REG_CAUSE   = 12'h003,
    REG_BPCTRL0 = 12'h010, REG_BPDATA0 = 12'h011,
    REG_BPCTRL1 = 12'h012, REG_BPDATA1 = 12'h013,
    REG_BPCTRL2 = 12'h014, REG_BPDATA2 = 12'h015,
    REG_BPCTRL3 = 12'h016, REG_BPDATA3 = 12'h017,
    REG_BPCTRL4 = 12'h018, REG_BPDATA4 = 12'h019,
    REG_BPCTRL5 = 12'h01A, REG_BPDATA5 = 12'h01B,
    REG_BPCTRL6 = 12'h01C, REG_BPDATA6 = 12'h01D,
    REG_BPCTRL7 = 12'h01E, REG_BPDATA7 = 12'h01F
  } dbg_reg_e;

  // CPU bank offsets, GPRs occupy 0x000..0x01F
  typedef enum logic [DU_ADDR_SIZE-1:0] {
    GPR_BASE = 12'h000,
    GPR_NPC  = 12'h200,
    GPR_PPC  = 12'h201
  } dbg_gpr_e;

  // Breakpoint compare select, codes 4..7 never hit
  typedef enum logic [2:0] {
    CC_FETCH    = 3'd0,
    CC_LD_ADR   = 3'd1,
    CC_ST_ADR   = 3'd2,
    CC_LDST_ADR = 3'd3
  } bp_cc_e;

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'h00,
    OPC_STORE  = 5'h08,
    OPC_BRANCH = 5'h18
  } opc_e;

endpackage

`default_nettype wire

// File: dbg_port.sv
// Debug port bank decode, acknowledge delay, CPU write strobes and read-data register
`timescale 1ns/1ps
`default_nettype none

module dbg_port #(
  parameter int XLEN = 32
) (
  input  logic                             clk,
  input  logic                             rstn,
  // Host side
  input  logic                             dbg_stall,
  input  logic                             dbg_strb,
  input  logic                             dbg_we,
  input  logic [dbg_pkg::DBG_AW-1:0]       dbg_addr,
  input  logic [XLEN-1:0]                  dbg_dati,
  output logic [XLEN-1:0]                  dbg_dato,
  output logic                             dbg_ack,
  // Pipeline side
  input  logic                             ex_stall,
  input  logic [XLEN-1:0]                  internal_rdata,
  input  logic [XLEN-1:0]                  du_dati_rf,
  input  logic [XLEN-1:0]                  id_pc,
  input  logic [XLEN-1:0]                  ex_pc,
  input  logic [XLEN-1:0]                  bu_nxt_pc,
  input  logic                             bu_flush,
  output logic                             du_we_rf,
  output logic                             du_we_pc,
  output logic                             we_internal,
  output logic [dbg_pkg::DU_ADDR_SIZE-1:0] du_addr,
  output logic [XLEN-1:0]                  du_dato
);
  import dbg_pkg::*;

  logic [BANK_W-1:0]       bank;
  logic [DU_ADDR_SIZE-1:0] offset;
  logic                    sel_internal;
  logic                    sel_gprs;
  logic                    gpr_window;
  logic                    strb_dly;
  logic                    du_access;
  logic                    du_we;
  logic [2:0]              ack_sr;

  //////////////////////////////////////////////////////////////////////
  // Address decode

  assign bank         = dbg_addr[DBG_AW-1:DU_ADDR_SIZE];
  assign offset       = dbg_addr[DU_ADDR_SIZE-1:0];
  assign sel_internal = bank == BANK_INTERNAL;
  assign sel_gprs     = bank == BANK_GPRS;
  // x0..x31
  assign gpr_window   = offset[DU_ADDR_SIZE-1:5] == '0;

  // CPU bank only reachable while the core is stalled
  assign du_access = dbg_strb & (dbg_stall | sel_internal);

  // First strobe cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strb_dly <= 1'b0;
    end else begin
      strb_dly <= dbg_strb;
    end
  end

  assign du_we = du_access & ~strb_dly & dbg_we;

  //////////////////////////////////////////////////////////////////////
  // Acknowledge

  // Ones shift in from the top, ack at bit 0, frozen by ex_stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_sr <= '0;
    end else if (!ex_stall) begin
      if (du_access && !dbg_ack) begin
        ack_sr <= {1'b1, ack_sr[2:1]};
      end else begin
        ack_sr <= '0;
      end
    end
  end

  assign dbg_ack = ack_sr[0];

  //////////////////////////////////////////////////////////////////////
  // Write strobes and payload

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_we_rf    <= 1'b0;
      du_we_pc    <= 1'b0;
      we_internal <= 1'b0;
    end else begin
      du_we_rf    <= du_we & sel_gprs & gpr_window;
      du_we_pc    <= du_we & sel_gprs & (offset == GPR_NPC);
      we_internal <= du_we & sel_internal;
    end
  end

  // Offset and data follow the host every cycle
  always_ff @(posedge clk) begin
    du_addr <= offset;
    du_dato <= dbg_dati;
  end

  // Read data, valid by the time ack rises
  always_ff @(posedge clk) begin
    if (sel_internal) begin
      dbg_dato <= internal_rdata;
    end else if (sel_gprs && gpr_window) begin
      dbg_dato <= du_dati_rf;
    end else if (sel_gprs && offset == GPR_NPC) begin
      // Branch unit overrides while redirecting
      dbg_dato <= bu_flush ? bu_nxt_pc : id_pc;
    end else if (sel_gprs && offset == GPR_PPC) begin
      dbg_dato <= ex_pc;
    end else begin
      dbg_dato <= '0;
    end
  end

endmodule

`default_nettype wire

// File: dbg_regs.sv
// Internal debug registers, sticky hit flags, cause encoder and internal read mux
`timescale 1ns/1ps
`default_nettype none

module dbg_regs #(
  parameter int XLEN        = 32,
  parameter int BREAKPOINTS = 3
) (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                we_internal,
  input  logic [dbg_pkg::DU_ADDR_SIZE-1:0]    du_addr,
  input  logic [XLEN-1:0]                     du_dato,
  input  logic [31:0]                         du_exceptions,
  input  logic                                bp_instr_hit,
  input  logic                                bp_branch_hit,
  input  logic [dbg_pkg::MAX_BREAKPOINTS-1:0] bp_hit,
  output logic [XLEN-1:0]                     internal_rdata,
  output logic [31:0]                         du_ie,
  output logic                                instr_break_ena,
  output logic                                branch_break_ena,
  output logic [dbg_pkg::MAX_BREAKPOINTS-1:0] bp_enabled,
  output dbg_pkg::bp_cc_e                     bp_cc [dbg_pkg::MAX_BREAKPOINTS],
  output logic [XLEN-1:0]                     bp_data [dbg_pkg::MAX_BREAKPOINTS],
  output logic                                hit_any
);
  import dbg_pkg::*;

  logic                       we_ctrl;
  logic                       we_hit;
  logic                       we_ie;
  logic                       we_cause;
  logic                       instr_hit_r;
  logic                       branch_hit_r;
  logic [MAX_BREAKPOINTS-1:0] bp_hit_r;
  logic [XLEN-1:0]            cause;
  logic                       bp_sel;
  logic [2:0]                 bp_slot;

  // Lowest set bit wins
  function automatic logic [3:0] lowest_idx(input logic [15:0] vec);
    logic [3:0] idx;
    idx = 4'd0;
    for (int i = 15; i >= 0; i--) begin
      if (vec[i]) idx = 4'(i);
    end
    return idx;
  endfunction

  assign we_ctrl  = we_internal && du_addr == REG_CTRL;
  assign we_hit   = we_internal && du_addr == REG_HIT;
  assign we_ie    = we_internal && du_addr == REG_IE;
  assign we_cause = we_internal && du_addr == REG_CAUSE;

  //////////////////////////////////////////////////////////////////////
  // CTRL, HIT, IE, CAUSE

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_break_ena  <= 1'b0;
      branch_break_ena <= 1'b0;
      du_ie            <= '0;
    end else begin
      if (we_ctrl) begin
        instr_break_ena  <= du_dato[0];
        branch_break_ena <= du_dato[1];
      end
      // Straight to the thread state
      if (we_ie) du_ie <= du_dato[31:0];
    end
  end

  // Sticky, host write beats a new hit
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_hit_r  <= 1'b0;
      branch_hit_r <= 1'b0;
    end else if (we_hit) begin
      instr_hit_r  <= du_dato[0];
      branch_hit_r <= du_dato[1];
    end else begin
      if (bp_instr_hit) instr_hit_r <= 1'b1;
      if (bp_branch_hit) branch_hit_r <= 1'b1;
    end
  end

  // Traps 0..15 before interrupts 16..31
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cause <= '0;
    end else if (we_cause) begin
      cause <= du_dato;
    end else if (|du_exceptions[15:0]) begin
      cause <= XLEN'(lowest_idx(du_exceptions[15:0]));
    end else if (|du_exceptions[31:16]) begin
      // Interrupt flag in the MSB
      cause <= {1'b1, (XLEN-1)'(lowest_idx(du_exceptions[31:16]))};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Breakpoint slots

  for (genvar n = 0; n < MAX_BREAKPOINTS; n++) begin : gen_bp
    localparam logic [DU_ADDR_SIZE-1:0] CTRL_OFS = DU_ADDR_SIZE'(REG_BPCTRL0 + 2 * n);
    localparam logic [DU_ADDR_SIZE-1:0] DATA_OFS = DU_ADDR_SIZE'(REG_BPDATA0 + 2 * n);

    if (n < BREAKPOINTS) begin : gen_impl
      logic            en_q;
      bp_cc_e          cc_q;
      logic [XLEN-1:0] data_q;
      logic            hit_q;

      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          en_q   <= 1'b0;
          cc_q   <= CC_FETCH;
          data_q <= '0;
          hit_q  <= 1'b0;
        end else begin
          if (we_internal && du_addr == CTRL_OFS) begin
            en_q <= du_dato[1];
            cc_q <= bp_cc_e'(du_dato[6:4]);
          end
          if (we_internal && du_addr == DATA_OFS) data_q <= du_dato;
          // Per-slot flag at HIT bit n+4
          if (we_hit) hit_q <= du_dato[n+4];
          else if (bp_hit[n]) hit_q <= 1'b1;
        end
      end

      assign bp_enabled[n] = en_q;
      assign bp_cc[n]      = cc_q;
      assign bp_data[n]    = data_q;
      assign bp_hit_r[n]   = hit_q;
    end else begin : gen_unimpl
      // Absent slot reads zero
      assign bp_enabled[n] = 1'b0;
      assign bp_cc[n]      = CC_FETCH;
      assign bp_data[n]    = '0;
      assign bp_hit_r[n]   = 1'b0;
    end
  end

  assign hit_any = instr_hit_r | branch_hit_r | (|bp_hit_r);

  //////////////////////////////////////////////////////////////////////
  // Read mux

  assign bp_sel  = du_addr >= REG_BPCTRL0 && du_addr <= REG_BPDATA7;
  assign bp_slot = du_addr[3:1];

  always_comb begin
    internal_rdata = '0;
    if (bp_sel) begin
      if (du_addr[0]) begin
        internal_rdata = bp_data[bp_slot];
      end else begin
        // cc, reserved, enable, implemented
        internal_rdata[6:0] = {bp_cc[bp_slot], 2'b00, bp_enabled[bp_slot],
                               bp_slot < BREAKPOINTS};
      end
    end else begin
      case (du_addr)
        REG_CTRL:  internal_rdata[1:0]  = {branch_break_ena, instr_break_ena};
        REG_HIT:   internal_rdata[11:0] = {bp_hit_r, 2'b00, branch_hit_r, instr_hit_r};
        REG_IE:    internal_rdata[31:0] = du_ie;
        REG_CAUSE: internal_rdata       = cause;
        default:   internal_rdata       = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dbg_unit.sv
// Debug unit top with port, register and match instances, halt pulse and resume flush
`timescale 1ns/1ps
`default_nettype none

module dbg_unit #(
  parameter int XLEN        = 32,
  parameter int BREAKPOINTS = 3
) (
  input  logic                             clk,
  input  logic                             rstn,
  // Host debug port
  input  logic                             dbg_stall,
  input  logic                             dbg_strb,
  input  logic                             dbg_we,
  input  logic [dbg_pkg::DBG_AW-1:0]       dbg_addr,
  input  logic [XLEN-1:0]                  dbg_dati,
  output logic [XLEN-1:0]                  dbg_dato,
  output logic                             dbg_ack,
  output logic                             dbg_bp,
  // Core control
  output logic                             du_stall,
  output logic                             du_stall_dly,
  output logic                             du_flush,
  output logic                             du_we_rf,
  output logic                             du_we_pc,
  output logic [dbg_pkg::DU_ADDR_SIZE-1:0] du_addr,
  output logic [XLEN-1:0]                  du_dato,
  output logic [31:0]                      du_ie,
  // Core state
  input  logic [XLEN-1:0]                  du_dati_rf,
  input  logic [XLEN-1:0]                  if_pc,
  input  logic [XLEN-1:0]                  id_pc,
  input  logic [XLEN-1:0]                  ex_pc,
  input  logic [XLEN-1:0]                  bu_nxt_pc,
  input  logic                             bu_flush,
  input  logic                             st_flush,
  input  logic [dbg_pkg::ILEN-1:0]         if_instr,
  input  logic [dbg_pkg::ILEN-1:0]         mem_instr,
  input  logic                             if_bubble,
  input  logic                             mem_bubble,
  input  logic [dbg_pkg::EXC_SIZE-1:0]     mem_exception,
  input  logic [XLEN-1:0]                  mem_memadr,
  input  logic                             dmem_ack,
  input  logic                             ex_stall,
  input  logic [31:0]                      du_exceptions
);
  import dbg_pkg::*;

  logic                       we_internal;
  logic [XLEN-1:0]            internal_rdata;
  logic                       instr_break_ena;
  logic                       branch_break_ena;
  logic [MAX_BREAKPOINTS-1:0] bp_enabled;
  bp_cc_e                     bp_cc [MAX_BREAKPOINTS];
  logic [XLEN-1:0]            bp_data [MAX_BREAKPOINTS];
  logic                       bp_instr_hit;
  logic                       bp_branch_hit;
  logic [MAX_BREAKPOINTS-1:0] bp_hit;
  logic                       hit_any;

  //////////////////////////////////////////////////////////////////////
  // Instances

  dbg_port #(.XLEN(XLEN)) i_dbg_port (
    .clk, .rstn,
    .dbg_stall, .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati, .dbg_dato, .dbg_ack,
    .ex_stall, .internal_rdata, .du_dati_rf, .id_pc, .ex_pc, .bu_nxt_pc, .bu_flush,
    .du_we_rf, .du_we_pc, .we_internal, .du_addr, .du_dato
  );

  dbg_regs #(.XLEN(XLEN), .BREAKPOINTS(BREAKPOINTS)) i_dbg_regs (
    .clk, .rstn,
    .we_internal, .du_addr, .du_dato, .du_exceptions,
    .bp_instr_hit, .bp_branch_hit, .bp_hit,
    .internal_rdata, .du_ie,
    .instr_break_ena, .branch_break_ena, .bp_enabled, .bp_cc, .bp_data,
    .hit_any
  );

  dbg_bp_match #(.XLEN(XLEN)) i_dbg_bp_match (
    .instr_break_ena, .branch_break_ena, .bp_enabled, .bp_cc, .bp_data,
    .if_pc, .if_instr, .if_bubble,
    .mem_instr, .mem_bubble, .mem_exception, .mem_memadr, .dmem_ack,
    .bu_flush, .st_flush,
    .bp_instr_hit, .bp_branch_hit, .bp_hit
  );

  //////////////////////////////////////////////////////////////////////
  // Halt and resume

  // Host stall goes straight to the core
  assign du_stall = dbg_stall;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_stall_dly <= 1'b0;
    end else begin
      du_stall_dly <= du_stall;
    end
  end

  // Leaving a halt with a pending exception drops the pipeline
  assign du_flush = du_stall_dly & ~dbg_stall & (|du_exceptions);

  // Halt request once the pipeline is quiet
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_bp <= 1'b0;
    end else begin
      dbg_bp <= ~ex_stall & ~du_stall & ~du_flush & ~bu_flush & ~st_flush &
                ((|du_exceptions) | hit_any);
    end
  end

endmodule

`default_nettype wire

// File: dbg_unit_props.sv
// Concurrent checks on debug port ack and write strobe timing bound into dbg_port
`timescale 1ns/1ps
`default_nettype none

module dbg_unit_props (
  input logic clk,
  input logic rstn,
  input logic dbg_strb,
  input logic dbg_ack,
  input logic du_we_rf,
  input logic du_we_pc,
  input logic we_internal
);

  // Failed property count
  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Port timing

  // Ack is a single-cycle pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack |=> !dbg_ack)
    else begin
      $error("dbg_ack stayed high for more than one cycle");
      fail_count++;
    end

  // Write strobes are single-cycle pulses
  a_we_pulse: assert property (@(posedge clk) disable iff (!rstn)
    (du_we_rf | du_we_pc | we_internal) |=> !(du_we_rf | du_we_pc | we_internal))
    else begin
      $error("write strobe stayed high for more than one cycle");
      fail_count++;
    end

  // Host still holds its strobe while acked
  a_ack_strb: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack |-> dbg_strb)
    else begin
      $error("dbg_ack raised without a strobe");
      fail_count++;
    end

endmodule

bind dbg_port dbg_unit_props i_dbg_unit_props (
  .clk         (clk),
  .rstn        (rstn),
  .dbg_strb    (dbg_strb),
  .dbg_ack     (dbg_ack),
  .du_we_rf    (du_we_rf),
  .du_we_pc    (du_we_pc),
  .we_internal (we_internal)
);

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_dbg_unit -o sim_dbg_unit
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_dbg_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// File: tb_dbg_unit.sv
// Testbench for the debug unit with LFSR stimulus, reference model, checks and report
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_unit;
  import dbg_pkg::*;

  localparam int XLEN         = 32;
  localparam int BREAKPOINTS  = 3;
  localparam int RESET_CYCLES = 16;
  // Upper bound on host accesses over all tests
  localparam int ACCESSES     = 300;
  localparam int CYCLE_LIMIT  = ACCESSES * 8 + RESET_CYCLES + 600;

  logic clk;
  logic rstn;
  logic dbg_stall, dbg_strb, dbg_we, dbg_ack, dbg_bp;
  logic [DBG_AW-1:0] dbg_addr;
  logic [XLEN-1:0] dbg_dati, dbg_dato;
  logic du_stall, du_stall_dly, du_flush, du_we_rf, du_we_pc;
  logic [DU_ADDR_SIZE-1:0] du_addr;
  logic [XLEN-1:0] du_dato;
  logic [31:0] du_ie;
  logic [XLEN-1:0] du_dati_rf, if_pc, id_pc, ex_pc, bu_nxt_pc, mem_memadr;
  logic bu_flush, st_flush, if_bubble, mem_bubble, dmem_ack, ex_stall;
  logic [ILEN-1:0] if_instr, mem_instr;
  logic [EXC_SIZE-1:0] mem_exception;
  logic [31:0] du_exceptions;

  // Reference model of the internal bank
  logic [1:0]  m_ctrl;
  logic [31:0] m_ie;
  logic        m_en [MAX_BREAKPOINTS];
  logic [2:0]  m_cc [MAX_BREAKPOINTS];
  logic [31:0] m_data [MAX_BREAKPOINTS];

  logic [31:0] lfsr = 32'h4954;
  int checks = 0;
  int errors = 0;
  int test_errs = 0;
  int cycles = 0;

  dbg_unit i_dbg_unit (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] bp_addr(input int n, input int is_data);
    return 16'(16 + 2 * n + is_data);
  endfunction

  // Expected BPCTRL readback with cc, enable and implemented flag
  function automatic logic [31:0] bpctrl_exp(input int n);
    if (n < BREAKPOINTS) return {25'd0, m_cc[n], 2'b00, m_en[n], 1'b1};
    return '0;
  endfunction

  function automatic logic [31:0] bpdata_exp(input int n);
    if (n < BREAKPOINTS) return m_data[n];
    return '0;
  endfunction

  // Traps before interrupts which carry the MSB
  function automatic logic [31:0] cause_exp(input logic [31:0] exc);
    for (int i = 0; i < 16; i++) begin
      if (exc[i]) return 32'(i);
    end
    for (int i = 16; i < 32; i++) begin
      if (exc[i]) return {1'b1, 31'(i - 16)};
    end
    return '0;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %s, %0d errors", name,
             (errors == test_errs) ? "passed" : "failed", errors - test_errs);
    test_errs = errors;
  endtask

  // One host access that counts unstalled edges up to the ack
  task automatic access(input logic [15:0] addr, input logic we, input logic [31:0] wdata,
                        input logic rand_stall, output logic [31:0] rdata);
    int   progress;
    int   waited;
    logic stall_cur;
    logic exp_rf;
    logic exp_pc;
    progress  = 0;
    waited    = 0;
    stall_cur = 1'b0;
    exp_rf = we && dbg_stall && addr[15:12] == 4'h1 && addr[11:5] == 7'd0;
    exp_pc = we && dbg_stall && addr[15:12] == 4'h1 && addr[11:0] == 12'h200;
    @(posedge clk);
    dbg_strb <= 1'b1;
    dbg_we   <= we;
    dbg_addr <= addr;
    dbg_dati <= wdata;
    ex_stall <= 1'b0;
    while (waited < 40) begin
      @(posedge clk);
      if (!stall_cur) progress++;
      // Stall only before the ack edge
      stall_cur = (rand_stall && progress < 3) ? (rnd(2) == 0) : 1'b0;
      ex_stall <= stall_cur;
      @(negedge clk);
      waited++;
      if (waited == 1) begin
        check_eq("du_we_rf", 32'(du_we_rf), 32'(exp_rf));
        check_eq("du_we_pc", 32'(du_we_pc), 32'(exp_pc));
        if (exp_rf || exp_pc) begin
          check_eq("du_addr", 32'(du_addr), 32'(addr[11:0]));
          check_eq("du_dato", du_dato, wdata);
        end
      end else begin
        check_eq("write strobes", 32'({du_we_rf, du_we_pc}), 32'd0);
      end
      if (dbg_ack) break;
    end
    checks++;
    assert (dbg_ack) else begin
      $display("No ack for address %h within %0d cycles", addr, waited);
      errors++;
    end
    check_eq("unstalled edges to ack", progress, 3);
    rdata = dbg_dato;
    @(posedge clk);
    dbg_strb <= 1'b0;
    ex_stall <= 1'b0;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Timeout

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] exc;
    logic [2:0]  cc;
    logic [1:0]  ctrl;
    logic        match, load, ack, fb, branch, ih, bh, bph;
    int          sel, n, kind;
    int          prop_fails;

    rstn = 1'b0;
    dbg_stall = 1'b0;
    dbg_strb = 1'b0;
    dbg_we = 1'b0;
    dbg_addr = '0;
    dbg_dati = '0;
    ex_stall = 1'b0;
    du_dati_rf = '0;
    id_pc = '0;
    ex_pc = '0;
    bu_nxt_pc = '0;
    bu_flush = 1'b0;
    st_flush = 1'b0;
    du_exceptions = '0;
    // Quiet pipeline whose PC and address never match masked breakpoint data
    if_pc = 32'h8000_0000;
    if_instr = '0;
    if_bubble = 1'b1;
    mem_instr = '0;
    mem_bubble = 1'b1;
    mem_exception = '0;
    mem_memadr = 32'h8000_0000;
    dmem_ack = 1'b0;
    m_ctrl = '0;
    m_ie = '0;
    for (int i = 0; i < MAX_BREAKPOINTS; i++) begin
      m_en[i] = 1'b0;
      m_cc[i] = '0;
      m_data[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;

    // Ack delay with random ex_stall
    for (int i = 0; i < 30; i++) access({4'h0, REG_CTRL}, 1'b0, '0, 1'b1, rd);
    // CPU bank while running
    @(posedge clk);
    dbg_strb <= 1'b1;
    dbg_we   <= 1'b0;
    dbg_addr <= {4'h1, GPR_PPC};
    repeat (10) begin
      @(negedge clk);
      check_eq("dbg_ack while running", 32'(dbg_ack), 32'd0);
    end
    @(posedge clk);
    dbg_strb <= 1'b0;
    @(posedge clk);
    report_test("ack timing");

    // Internal register write and readback
    for (int i = 0; i < 40; i++) begin
      sel = int'(rnd(3));
      n   = int'(rnd(3));
      wd  = rnd(32);
      if (sel == 0) begin
        access({4'h0, REG_CTRL}, 1'b1, wd, 1'b0, rd);
        m_ctrl = wd[1:0];
        access({4'h0, REG_CTRL}, 1'b0, '0, 1'b0, rd);
        check_eq("CTRL", rd, 32'(m_ctrl));
      end else if (sel == 1) begin
        access({4'h0, REG_IE}, 1'b1, wd, 1'b0, rd);
        m_ie = wd;
        access({4'h0, REG_IE}, 1'b0, '0, 1'b0, rd);
        check_eq("IE", rd, m_ie);
      end else if (sel < 5) begin
        access(bp_addr(n, 0), 1'b1, wd, 1'b0, rd);
        if (n < BREAKPOINTS) begin
          m_en[n] = wd[1];
          m_cc[n] = wd[6:4];
        end
        access(bp_addr(n, 0), 1'b0, '0, 1'b0, rd);
        check_eq("BPCTRL", rd, bpctrl_exp(n));
      end else begin
        wd = wd & 32'h7FFF_FFFC;
        access(bp_addr(n, 1), 1'b1, wd, 1'b0, rd);
        if (n < BREAKPOINTS) m_data[n] = wd;
        access(bp_addr(n, 1), 1'b0, '0, 1'b0, rd);
        check_eq("BPDATA", rd, bpdata_exp(n));
      end
      check_eq("du_ie", du_ie, m_ie);
    end
    for (int i = 0; i < MAX_BREAKPOINTS; i++) begin
      access(bp_addr(i, 0), 1'b0, '0, 1'b0, rd);
      check_eq("BPCTRL sweep", rd, bpctrl_exp(i));
      access(bp_addr(i, 1), 1'b0, '0, 1'b0, rd);
      check_eq("BPDATA sweep", rd, bpdata_exp(i));
    end
    report_test("internal registers");

    // CPU bank with the core halted
    @(posedge clk);
    dbg_stall <= 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      du_dati_rf <= rnd(32);
      id_pc      <= rnd(32);
      ex_pc      <= rnd(32);
      bu_nxt_pc  <= rnd(32);
      bu_flush   <= 1'(rnd(1));
      wd = rnd(32);
      if (rnd(1) == 0) access({4'h1, 7'd0, 5'(rnd(5))}, 1'b1, wd, 1'b0, rd);
      else access({4'h1, GPR_NPC}, 1'b1, wd, 1'b0, rd);
      kind = int'(rnd(2));
      if (kind == 0) begin
        access({4'h1, 7'd0, 5'(rnd(5))}, 1'b0, '0, 1'b0, rd);
        check_eq("GPR read", rd, du_dati_rf);
      end else if (kind == 1) begin
        access({4'h1, GPR_PPC}, 1'b0, '0, 1'b0, rd);
        check_eq("PPC read", rd, ex_pc);
      end else begin
        access({4'h1, GPR_NPC}, 1'b0, '0, 1'b0, rd);
        check_eq("NPC read", rd, bu_flush ? bu_nxt_pc : id_pc);
      end
    end
    @(posedge clk);
    dbg_stall <= 1'b0;
    bu_flush  <= 1'b0;
    report_test("cpu bank");

    // Cause priority
    for (int i = 0; i < 16; i++) begin
      exc = rnd(32);
      if (rnd(1) == 0) exc[15:0] = '0;
      if (exc == 0) exc = 32'h8000_0000;
      @(posedge clk);
      du_exceptions <= exc;
      @(posedge clk);
      du_exceptions <= '0;
      access({4'h0, REG_CAUSE}, 1'b0, '0, 1'b0, rd);
      check_eq("CAUSE", rd, cause_exp(exc));
    end
    report_test("cause encoding");

    // Breakpoints, single step and branch break
    for (int i = 0; i < BREAKPOINTS; i++) begin
      access(bp_addr(i, 0), 1'b1, '0, 1'b0, rd);
      m_en[i] = 1'b0;
      m_cc[i] = '0;
    end
    for (int i = 0; i < 12; i++) begin
      n    = int'(rnd(2)) % BREAKPOINTS;
      cc   = 3'(rnd(2));
      wd   = rnd(32) & 32'h7FFF_FFFC;
      ctrl = 2'(rnd(2));
      access({4'h0, REG_HIT}, 1'b1, '0, 1'b0, rd);
      access({4'h0, REG_CTRL}, 1'b1, 32'(ctrl), 1'b0, rd);
      access(bp_addr(n, 0), 1'b1, {25'd0, cc, 4'b0010}, 1'b0, rd);
      access(bp_addr(n, 1), 1'b1, wd, 1'b0, rd);
      m_ctrl = ctrl;
      m_en[n] = 1'b1;
      m_cc[n] = cc;
      m_data[n] = wd;
      match  = 1'(rnd(1));
      load   = 1'(rnd(1));
      ack    = 1'(rnd(1));
      fb     = 1'(rnd(1));
      branch = 1'(rnd(1));
      @(posedge clk);
      if_pc      <= (cc == 3'd0 && match) ? wd : wd ^ 32'h4;
      if_bubble  <= fb;
      if_instr   <= {25'(rnd(25)), branch ? OPC_BRANCH : 5'h04, 2'b11};
      mem_bubble <= 1'b0;
      mem_instr  <= {25'd0, load ? OPC_LOAD : OPC_STORE, 2'b11};
      mem_memadr <= (cc != 3'd0 && match) ? wd : wd ^ 32'h8;
      dmem_ack   <= ack;
      @(posedge clk);
      if_pc      <= 32'h8000_0000;
      if_bubble  <= 1'b1;
      mem_bubble <= 1'b1;
      mem_memadr <= 32'h8000_0000;
      dmem_ack   <= 1'b0;
      // Hit rules for the model
      ih  = m_ctrl[0] & ~fb;
      bh  = m_ctrl[1] & ~fb & branch;
      bph = match & ((cc == 3'd0) |
                     (ack & ((cc == 3'd1 & load) | (cc == 3'd2 & ~load) | (cc == 3'd3))));
      // Sticky flags were still clear on this edge
      @(negedge clk);
      check_eq("dbg_bp before flags", 32'(dbg_bp), 32'd0);
      // Halt pulse follows the registered hit flags
      @(negedge clk);
      check_eq("dbg_bp after hit", 32'(dbg_bp), 32'(ih | bh | bph));
      access({4'h0, REG_HIT}, 1'b0, '0, 1'b0, rd);
      check_eq("HIT", rd, (32'(bph) << (n + 4)) | 32'({bh, ih}));
      access(bp_addr(n, 0), 1'b1, '0, 1'b0, rd);
      m_en[n] = 1'b0;
      m_cc[n] = '0;
    end
    access({4'h0, REG_CTRL}, 1'b1, '0, 1'b0, rd);
    access({4'h0, REG_HIT}, 1'b1, '0, 1'b0, rd);
    m_ctrl = '0;
    report_test("breakpoints");

    // Halt then resume with a held exception vector
    for (int i = 0; i < 10; i++) begin
      exc = rnd(32);
      if (rnd(1) == 0) exc = '0;
      @(posedge clk);
      dbg_stall     <= 1'b1;
      du_exceptions <= exc;
      @(negedge clk);
      check_eq("du_stall high", 32'(du_stall), 32'd1);
      check_eq("du_stall_dly lag", 32'(du_stall_dly), 32'd0);
      repeat (2) @(posedge clk);
      dbg_stall <= 1'b0;
      @(negedge clk);
      check_eq("du_stall low", 32'(du_stall), 32'd0);
      check_eq("du_stall_dly trail", 32'(du_stall_dly), 32'd1);
      check_eq("du_flush on resume", 32'(du_flush), 32'(|exc));
      @(negedge clk);
      check_eq("du_stall_dly cleared", 32'(du_stall_dly), 32'd0);
      check_eq("du_flush cleared", 32'(du_flush), 32'd0);
      @(posedge clk);
      du_exceptions <= '0;
    end
    report_test("resume flush");

    // Bound port properties count their own failures
    prop_fails = i_dbg_unit.i_dbg_port.i_dbg_unit_props.fail_count;
    $display("Checks: %0d passed, %0d failed, %0d property failures",
             checks - errors, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
dbg_pkg.sv
dbg_port.sv
dbg_regs.sv
dbg_bp_match.sv
dbg_unit.sv
dbg_unit_props.sv
tb_dbg_unit.sv
